// File: src/core_pkg.sv
package core_pkg;

    // program space the pc can address
    localparam int MAIN_MEMORY_BYTES = 2048;
    localparam int PC_BITS = $clog2(MAIN_MEMORY_BYTES);  // 11 for 2 KiB

    localparam int XLEN = 32;
    localparam int REG_IDX_BITS = 5;

    // one data word, register value or alu result
    typedef logic [XLEN-1:0] word_t;

    // x0..x31
    typedef logic [REG_IDX_BITS-1:0] reg_idx_t;

    // byte address into the program space
    typedef logic [PC_BITS-1:0] pc_t;

endpackage

// File: src/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_control_t;

    typedef enum logic {ALU_SRC_A_REG, ALU_SRC_A_PC} alu_src_a_t;

    typedef enum logic {ALU_SRC_B_REG, ALU_SRC_B_IMM} alu_src_b_t;

    // PC: pc + imm, REG: alu result (rs1 + imm)
    typedef enum logic {JUMP_SRC_PC, JUMP_SRC_REG} jump_src_t;

    typedef enum logic {RESULT_ALU, RESULT_PC_PLUS_4} result_src_t;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,  // register file
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_t;

endpackage

// File: src/op_if.sv
`timescale 1ns/1ps

interface op_if;
    import core_pkg::*;
    import ctrl_pkg::*;

    logic         valid;
    pc_t          pc;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        imm;      // already sign extended
    alu_control_t alu_control;
    alu_src_a_t   alu_src_a;
    alu_src_b_t   alu_src_b;
    jump_src_t    jump_src;
    logic         branch;
    logic         jump;
    logic         invert_cond;
    logic         reg_write;
    result_src_t  result_src;

    modport front (
        output valid, pc, rs1, rs2, rd, imm, alu_control, alu_src_a, alu_src_b,
        output jump_src, branch, jump, invert_cond, reg_write, result_src
    );

    modport exe (
        input valid, pc, rs1, rs2, rd, imm, alu_control, alu_src_a, alu_src_b,
        input jump_src, branch, jump, invert_cond, reg_write, result_src
    );

endinterface

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output core_pkg::word_t    rs1_value,
    output core_pkg::word_t    rs2_value,
    input  logic               we,
    input  core_pkg::reg_idx_t rd,
    input  core_pkg::word_t    wd
);
    import core_pkg::*;

    word_t regs [1:31];  // no storage behind x0

    function automatic word_t read_port(reg_idx_t idx);
        word_t value;
        if (idx == '0) begin
            value = '0;
        end else if (we && idx == rd) begin
            value = wd;  // write-through, covers wb to decode
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb begin
        rs1_value = read_port(rs1);
        rs2_value = read_port(rs2);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    input  core_pkg::word_t        src_a,
    input  core_pkg::word_t        src_b,
    input  ctrl_pkg::alu_control_t control,
    input  logic                   invert_cond,
    output core_pkg::word_t        result,
    output logic                   take_branch
);
    import ctrl_pkg::*;

    logic [4:0] shamt;
    logic       cond;

    assign shamt = src_b[4:0];

    always_comb begin
        case (control)
            ALU_ADD:  result = src_a + src_b;
            ALU_SUB:  result = src_a - src_b;
            ALU_AND:  result = src_a & src_b;
            ALU_OR:   result = src_a | src_b;
            ALU_XOR:  result = src_a ^ src_b;
            ALU_SLL:  result = src_a << shamt;
            ALU_SRL:  result = src_a >> shamt;
            ALU_SRA:  result = $signed(src_a) >>> shamt;
            ALU_SLT:  result = {31'b0, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: result = {31'b0, src_a < src_b};
            default:  result = '0;
        endcase
    end

    // beq/bne from SUB, blt/bge and bltu/bgeu from the compares
    always_comb begin
        case (control)
            ALU_SUB:  cond = (result == '0);
            ALU_SLT,
            ALU_SLTU: cond = result[0];
            default:  cond = 1'b0;
        endcase
    end

    assign take_branch = cond ^ invert_cond;

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    op_if.exe                   op,
    input  core_pkg::word_t     rs1_value,
    input  core_pkg::word_t     rs2_value,
    input  ctrl_pkg::fwd_sel_t  forward_a,
    input  ctrl_pkg::fwd_sel_t  forward_b,
    input  logic                flush,
    input  core_pkg::word_t     m_result,
    input  core_pkg::word_t     w_result,
    output core_pkg::reg_idx_t  e_rs1,
    output core_pkg::reg_idx_t  e_rs2,
    output core_pkg::reg_idx_t  e_rd,
    output logic                e_reg_write,
    output core_pkg::word_t     e_result,
    output logic                redirect,
    output core_pkg::pc_t       pc_target
);
    import core_pkg::*;
    import ctrl_pkg::*;

    logic         load;
    pc_t          e_pc;
    word_t        e_rs1_value;
    word_t        e_rs2_value;
    word_t        e_imm;
    alu_control_t e_alu_control;
    alu_src_a_t   e_alu_src_a;
    alu_src_b_t   e_alu_src_b;
    jump_src_t    e_jump_src;
    result_src_t  e_result_src;
    logic         e_branch;
    logic         e_jump;
    logic         e_invert_cond;
    word_t        src_a_reg;
    word_t        src_b_reg;
    word_t        src_a;
    word_t        src_b;
    word_t        alu_result;
    logic         take_branch;
    pc_t          pc_plus_4;

    assign load = op.valid && !flush;  // squashed or idle slot becomes a bubble

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_pc          <= '0;
            e_rs1_value   <= '0;
            e_rs2_value   <= '0;
            e_imm         <= '0;
            e_rs1         <= '0;
            e_rs2         <= '0;
            e_rd          <= '0;
            e_alu_control <= ALU_ADD;
            e_alu_src_a   <= ALU_SRC_A_REG;
            e_alu_src_b   <= ALU_SRC_B_REG;
            e_jump_src    <= JUMP_SRC_PC;
            e_result_src  <= RESULT_ALU;
            e_branch      <= 1'b0;
            e_jump        <= 1'b0;
            e_invert_cond <= 1'b0;
            e_reg_write   <= 1'b0;
        end else begin
            e_pc          <= load ? op.pc : '0;
            e_rs1_value   <= load ? rs1_value : '0;
            e_rs2_value   <= load ? rs2_value : '0;
            e_imm         <= load ? op.imm : '0;
            e_rs1         <= load ? op.rs1 : '0;
            e_rs2         <= load ? op.rs2 : '0;
            e_rd          <= load ? op.rd : '0;
            e_alu_control <= load ? op.alu_control : ALU_ADD;
            e_alu_src_a   <= load ? op.alu_src_a : ALU_SRC_A_REG;
            e_alu_src_b   <= load ? op.alu_src_b : ALU_SRC_B_REG;
            e_jump_src    <= load ? op.jump_src : JUMP_SRC_PC;
            e_result_src  <= load ? op.result_src : RESULT_ALU;
            e_branch      <= load && op.branch;
            e_jump        <= load && op.jump;
            e_invert_cond <= load && op.invert_cond;
            e_reg_write   <= load && op.reg_write;
        end
    end

    always_comb begin
        case (forward_a)
            FWD_WB:  src_a_reg = w_result;
            FWD_MEM: src_a_reg = m_result;
            default: src_a_reg = e_rs1_value;
        endcase
        case (forward_b)
            FWD_WB:  src_b_reg = w_result;
            FWD_MEM: src_b_reg = m_result;
            default: src_b_reg = e_rs2_value;
        endcase
        src_a = (e_alu_src_a == ALU_SRC_A_PC) ? word_t'(e_pc) : src_a_reg;
        src_b = (e_alu_src_b == ALU_SRC_B_IMM) ? e_imm : src_b_reg;
    end

    alu i_alu (
        .src_a       (src_a),
        .src_b       (src_b),
        .control     (e_alu_control),
        .invert_cond (e_invert_cond),
        .result      (alu_result),
        .take_branch (take_branch)
    );

    assign pc_plus_4 = e_pc + pc_t'(4);
    assign pc_target = (e_jump_src == JUMP_SRC_REG) ? alu_result[PC_BITS-1:0]
                                                    : e_pc + e_imm[PC_BITS-1:0];
    assign redirect  = e_jump || (e_branch && take_branch);
    assign e_result  = (e_result_src == RESULT_PC_PLUS_4) ? word_t'(pc_plus_4) : alu_result;

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  core_pkg::reg_idx_t e_rs1,
    input  core_pkg::reg_idx_t e_rs2,
    input  core_pkg::reg_idx_t m_rd,
    input  logic               m_reg_write,
    input  core_pkg::reg_idx_t w_rd,
    input  logic               w_reg_write,
    input  logic               redirect,
    output ctrl_pkg::fwd_sel_t forward_a,
    output ctrl_pkg::fwd_sel_t forward_b,
    output logic               flush
);
    import core_pkg::*;
    import ctrl_pkg::*;

    // the younger producer in the memory stage wins over writeback
    function automatic fwd_sel_t pick_source(reg_idx_t rs);
        fwd_sel_t sel;
        if (m_reg_write && m_rd != '0 && m_rd == rs) begin
            sel = FWD_MEM;
        end else if (w_reg_write && w_rd != '0 && w_rd == rs) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_NONE;
        end
        return sel;
    endfunction

    always_comb begin
        forward_a = pick_source(e_rs1);
        forward_b = pick_source(e_rs2);
    end

    assign flush = redirect;  // kill the op entering execute

endmodule

// File: src/retire_pipe.sv
`timescale 1ns/1ps

module retire_pipe (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t e_rd,
    input  logic               e_reg_write,
    input  core_pkg::word_t    e_result,
    output core_pkg::reg_idx_t m_rd,
    output logic               m_reg_write,
    output core_pkg::word_t    m_result,
    output core_pkg::reg_idx_t w_rd,
    output logic               w_reg_write,
    output core_pkg::word_t    w_result
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_rd        <= '0;
            m_reg_write <= 1'b0;
            m_result    <= '0;
        end else begin
            m_rd        <= e_rd;
            m_reg_write <= e_reg_write && e_rd != '0;  // x0 writes die here
            m_result    <= e_result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_rd        <= '0;
            w_reg_write <= 1'b0;
            w_result    <= '0;
        end else begin
            w_rd        <= m_rd;
            w_reg_write <= m_reg_write;
            w_result    <= m_result;
        end
    end

endmodule

// File: src/exec_core.sv
`timescale 1ns/1ps

module exec_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   op_valid,
    input  core_pkg::pc_t          op_pc,
    input  core_pkg::reg_idx_t     op_rs1,
    input  core_pkg::reg_idx_t     op_rs2,
    input  core_pkg::reg_idx_t     op_rd,
    input  core_pkg::word_t        op_imm,
    input  ctrl_pkg::alu_control_t op_alu_control,
    input  ctrl_pkg::alu_src_a_t   op_alu_src_a,
    input  ctrl_pkg::alu_src_b_t   op_alu_src_b,
    input  ctrl_pkg::jump_src_t    op_jump_src,
    input  logic                   op_branch,
    input  logic                   op_jump,
    input  logic                   op_invert_cond,
    input  logic                   op_reg_write,
    input  ctrl_pkg::result_src_t  op_result_src,
    output logic                   redirect,
    output core_pkg::pc_t          pc_target,
    output logic                   wb_valid,
    output core_pkg::reg_idx_t     wb_rd,
    output core_pkg::word_t        wb_data
);

    op_if op_bus ();

    core_pkg::word_t     rs1_value;
    core_pkg::word_t     rs2_value;
    ctrl_pkg::fwd_sel_t  forward_a;
    ctrl_pkg::fwd_sel_t  forward_b;
    logic                flush;
    core_pkg::reg_idx_t  e_rs1;
    core_pkg::reg_idx_t  e_rs2;
    core_pkg::reg_idx_t  e_rd;
    logic                e_reg_write;
    core_pkg::word_t     e_result;
    core_pkg::reg_idx_t  m_rd;
    logic                m_reg_write;
    core_pkg::word_t     m_result;

    // front end ports onto the operation bus
    assign op_bus.valid       = op_valid;
    assign op_bus.pc          = op_pc;
    assign op_bus.rs1         = op_rs1;
    assign op_bus.rs2         = op_rs2;
    assign op_bus.rd          = op_rd;
    assign op_bus.imm         = op_imm;
    assign op_bus.alu_control = op_alu_control;
    assign op_bus.alu_src_a   = op_alu_src_a;
    assign op_bus.alu_src_b   = op_alu_src_b;
    assign op_bus.jump_src    = op_jump_src;
    assign op_bus.branch      = op_branch;
    assign op_bus.jump        = op_jump;
    assign op_bus.invert_cond = op_invert_cond;
    assign op_bus.reg_write   = op_reg_write;
    assign op_bus.result_src  = op_result_src;

    reg_file i_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (op_bus.rs1),
        .rs2       (op_bus.rs2),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .we        (wb_valid),
        .rd        (wb_rd),
        .wd        (wb_data)
    );

    execute_stage i_execute_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .op          (op_bus.exe),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .forward_a   (forward_a),
        .forward_b   (forward_b),
        .flush       (flush),
        .m_result    (m_result),
        .w_result    (wb_data),
        .e_rs1       (e_rs1),
        .e_rs2       (e_rs2),
        .e_rd        (e_rd),
        .e_reg_write (e_reg_write),
        .e_result    (e_result),
        .redirect    (redirect),
        .pc_target   (pc_target)
    );

    hazard_unit i_hazard_unit (
        .e_rs1       (e_rs1),
        .e_rs2       (e_rs2),
        .m_rd        (m_rd),
        .m_reg_write (m_reg_write),
        .w_rd        (wb_rd),
        .w_reg_write (wb_valid),
        .redirect    (redirect),
        .forward_a   (forward_a),
        .forward_b   (forward_b),
        .flush       (flush)
    );

    // writeback stage doubles as the observed write port
    retire_pipe i_retire_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .e_rd        (e_rd),
        .e_reg_write (e_reg_write),
        .e_result    (e_result),
        .m_rd        (m_rd),
        .m_reg_write (m_reg_write),
        .m_result    (m_result),
        .w_rd        (wb_rd),
        .w_reg_write (wb_valid),
        .w_result    (wb_data)
    );

endmodule

// File: tb/exec_core_chk.sv
`timescale 1ns/1ps

module exec_core_chk (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               redirect,
    input  logic               wb_valid,
    input  core_pkg::reg_idx_t wb_rd
);

    int unsigned error_count = 0;

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_rd != '0)
        else begin
            $error("writeback to x0 is visible on the write port");
            error_count++;
        end

    // the slot behind a redirect is a bubble
    redirect_single: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect)
        else begin
            $error("redirect held for two cycles");
            error_count++;
        end

    squash_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> ##3 !wb_valid)
        else begin
            $error("operation squashed by a redirect still wrote back");
            error_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !redirect && !wb_valid)
        else begin
            $error("redirect or wb_valid high during reset");
            error_count++;
        end

endmodule

// File: tb/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;
    import core_pkg::*;
    import ctrl_pkg::*;

    localparam int N_OPS          = 3000;
    localparam int DRAIN_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = N_OPS * 10 + 200;

    logic         clk;
    logic         rst_n;
    logic         op_valid;
    pc_t          op_pc;
    reg_idx_t     op_rs1;
    reg_idx_t     op_rs2;
    reg_idx_t     op_rd;
    word_t        op_imm;
    alu_control_t op_alu_control;
    alu_src_a_t   op_alu_src_a;
    alu_src_b_t   op_alu_src_b;
    jump_src_t    op_jump_src;
    logic         op_branch;
    logic         op_jump;
    logic         op_invert_cond;
    logic         op_reg_write;
    result_src_t  op_result_src;
    logic         redirect;
    pc_t          pc_target;
    logic         wb_valid;
    reg_idx_t     wb_rd;
    word_t        wb_data;

    word_t        model_regs [32];  // architectural state in program order
    logic         exp_valid [3];    // index 0 is the op presented this cycle
    reg_idx_t     exp_rd [3];
    word_t        exp_data [3];
    logic         exp_redirect;
    pc_t          exp_target;

    exec_core i_exec_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_valid       (op_valid),
        .op_pc          (op_pc),
        .op_rs1         (op_rs1),
        .op_rs2         (op_rs2),
        .op_rd          (op_rd),
        .op_imm         (op_imm),
        .op_alu_control (op_alu_control),
        .op_alu_src_a   (op_alu_src_a),
        .op_alu_src_b   (op_alu_src_b),
        .op_jump_src    (op_jump_src),
        .op_branch      (op_branch),
        .op_jump        (op_jump),
        .op_invert_cond (op_invert_cond),
        .op_reg_write   (op_reg_write),
        .op_result_src  (op_result_src),
        .redirect       (redirect),
        .pc_target      (pc_target),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

    bind exec_core exec_core_chk i_exec_core_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect  (redirect),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd)
    );

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic value_mismatch(string field, word_t got, word_t want);
        abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                            $time, field, got, want));
    endtask

    function automatic word_t alu_model(alu_control_t ctl, word_t a, word_t b);
        word_t r;
        case (ctl)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLL:  r = a << b[4:0];
            ALU_SRL:  r = a >> b[4:0];
            ALU_SRA:  r = word_t'($signed(a) >>> b[4:0]);
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            default:  r = '0;
        endcase
        return r;
    endfunction

    task automatic drive_idle();
        op_valid       <= 1'b0;
        op_pc          <= '0;
        op_rs1         <= '0;
        op_rs2         <= '0;
        op_rd          <= '0;
        op_imm         <= '0;
        op_alu_control <= ALU_ADD;
        op_alu_src_a   <= ALU_SRC_A_REG;
        op_alu_src_b   <= ALU_SRC_B_REG;
        op_jump_src    <= JUMP_SRC_PC;
        op_branch      <= 1'b0;
        op_jump        <= 1'b0;
        op_invert_cond <= 1'b0;
        op_reg_write   <= 1'b0;
        op_result_src  <= RESULT_ALU;
    endtask

    // x0..x7 only, so dependencies at distance 1..3 are frequent
    task automatic drive_random_op();
        int unsigned kind;
        kind = $urandom_range(9);
        op_valid       <= ($urandom_range(7) != 0);
        op_pc          <= pc_t'($urandom) & pc_t'(11'h7fc);
        op_rs1         <= reg_idx_t'($urandom_range(7));
        op_rs2         <= reg_idx_t'($urandom_range(7));
        op_rd          <= reg_idx_t'($urandom_range(7));
        op_imm         <= ($urandom_range(3) == 0) ? word_t'($urandom)
                                                   : word_t'(int'($urandom_range(4095)) - 2048);
        op_alu_control <= alu_control_t'($urandom_range(9));
        op_alu_src_a   <= (kind == 4) ? ALU_SRC_A_PC : ALU_SRC_A_REG;
        op_alu_src_b   <= alu_src_b_t'($urandom_range(1));
        op_jump_src    <= JUMP_SRC_PC;
        op_branch      <= 1'b0;
        op_jump        <= 1'b0;
        op_invert_cond <= 1'($urandom_range(1));
        op_reg_write   <= 1'b1;
        op_result_src  <= RESULT_ALU;
        if (kind <= 1) begin  // conditional branch
            op_branch      <= 1'b1;
            op_reg_write   <= 1'b0;
            op_alu_src_b   <= ALU_SRC_B_REG;
            op_alu_control <= $urandom_range(1) ? ALU_SUB
                                                : ($urandom_range(1) ? ALU_SLT : ALU_SLTU);
        end else if (kind <= 3) begin  // jal or jalr
            op_jump        <= 1'b1;
            op_alu_src_a   <= (kind == 2) ? ALU_SRC_A_PC : ALU_SRC_A_REG;
            op_alu_src_b   <= ALU_SRC_B_IMM;
            op_alu_control <= ALU_ADD;
            op_jump_src    <= (kind == 2) ? JUMP_SRC_PC : JUMP_SRC_REG;
            op_result_src  <= RESULT_PC_PLUS_4;
        end
    endtask

    task automatic check_outputs();
        assert (i_exec_core.i_exec_core_chk.error_count == 0)
            else abort_run("ERROR: an assertion in the bound checker failed");
        assert (redirect == exp_redirect)
            else value_mismatch("redirect", word_t'(redirect), word_t'(exp_redirect));
        if (exp_redirect) begin
            assert (pc_target == exp_target)
                else value_mismatch("pc_target", word_t'(pc_target), word_t'(exp_target));
        end
        assert (wb_valid == exp_valid[2])
            else value_mismatch("wb_valid", word_t'(wb_valid), word_t'(exp_valid[2]));
        if (exp_valid[2]) begin
            assert (wb_rd == exp_rd[2])
                else value_mismatch("wb_rd", word_t'(wb_rd), word_t'(exp_rd[2]));
            assert (wb_data == exp_data[2]) else value_mismatch("wb_data", wb_data, exp_data[2]);
        end
    endtask

    task automatic model_presented_op();
        logic  squashed;
        logic  cond;
        word_t a;
        word_t b;
        word_t res;
        squashed = exp_redirect;  // previous op redirected in this cycle
        for (int i = 2; i > 0; i--) begin
            exp_valid[i] = exp_valid[i-1];
            exp_rd[i]    = exp_rd[i-1];
            exp_data[i]  = exp_data[i-1];
        end
        exp_valid[0] = 1'b0;
        exp_redirect = 1'b0;
        if (op_valid && !squashed) begin
            a    = (op_alu_src_a == ALU_SRC_A_PC) ? word_t'(op_pc) : model_regs[op_rs1];
            b    = (op_alu_src_b == ALU_SRC_B_IMM) ? op_imm : model_regs[op_rs2];
            res  = alu_model(op_alu_control, a, b);
            cond = 1'b0;
            if (op_alu_control == ALU_SUB) begin
                cond = (res == '0);
            end else if (op_alu_control == ALU_SLT || op_alu_control == ALU_SLTU) begin
                cond = res[0];
            end
            exp_redirect = op_jump || (op_branch && (cond ^ op_invert_cond));
            exp_target   = (op_jump_src == JUMP_SRC_REG) ? res[PC_BITS-1:0]
                                                         : op_pc + op_imm[PC_BITS-1:0];
            if (op_reg_write && op_rd != '0) begin
                exp_valid[0] = 1'b1;
                exp_rd[0]    = op_rd;
                exp_data[0]  = (op_result_src == RESULT_PC_PLUS_4)
                             ? word_t'(pc_t'(op_pc + pc_t'(4))) : res;
                model_regs[op_rd] = exp_data[0];
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * 10);
        abort_run("ERROR: watchdog timeout, the test did not finish in time");
    end

    initial begin
        void'($urandom(4));
        rst_n = 1'b0;
        drive_idle();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            exp_valid[i] = 1'b0;
            exp_rd[i]    = '0;
            exp_data[i]  = '0;
        end
        exp_redirect = 1'b0;
        exp_target   = '0;
        repeat (7) @(posedge clk);
        @(negedge clk);
        assert (!redirect) else value_mismatch("redirect in reset", word_t'(redirect), '0);
        assert (!wb_valid) else value_mismatch("wb_valid in reset", word_t'(wb_valid), '0);
        @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < N_OPS + DRAIN_CYCLES; n++) begin
            @(posedge clk);
            if (n < N_OPS) begin
                drive_random_op();
            end else begin
                drive_idle();
            end
            @(negedge clk);
            check_outputs();
            model_presented_op();
        end
        if (i_exec_core.i_exec_core_chk.error_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("ERROR: an assertion in the bound checker failed");
        end
    end

endmodule

// File: src.f
src/core_pkg.sv
src/ctrl_pkg.sv
src/op_if.sv
src/reg_file.sv
src/alu.sv
src/execute_stage.sv
src/hazard_unit.sv
src/retire_pipe.sv
src/exec_core.sv
tb/exec_core_chk.sv
tb/tb_exec_core.sv

// File: Bender.yml
package:
  name: exec_core

sources:
  - src/core_pkg.sv
  - src/ctrl_pkg.sv
  - src/op_if.sv
  - src/reg_file.sv
  - src/alu.sv
  - src/execute_stage.sv
  - src/hazard_unit.sv
  - src/retire_pipe.sv
  - src/exec_core.sv
  - target: test
    files:
      - tb/exec_core_chk.sv
      - tb/tb_exec_core.sv
